//--- lock_pkg.sv
package lock_pkg;

    localparam int code_w  = 12; // three bcd digits
    localparam int digit_w = 4;
    localparam int bcd_w   = 8;  // two-digit countdown

    // keypad meanings with digits at their own value
    typedef enum logic [3:0] {
        key_0           = 4'd0,
        key_1           = 4'd1,
        key_2           = 4'd2,
        key_3           = 4'd3,
        key_4           = 4'd4,
        key_5           = 4'd5,
        key_6           = 4'd6,
        key_7           = 4'd7,
        key_8           = 4'd8,
        key_9           = 4'd9,
        key_enter       = 4'd10,
        key_set         = 4'd11,
        key_clear       = 4'd12,
        key_reset_tries = 4'd13,
        key_none        = 4'd15
    } key_t;

    typedef enum logic [1:0] {
        st_entry    = 2'd0,
        st_set      = 2'd1,
        st_unlocked = 2'd2,
        st_lockout  = 2'd3
    } lock_state_t;

    // higher value means higher priority
    typedef enum logic [1:0] {
        tone_click = 2'd0,
        tone_pass  = 2'd1,
        tone_fail  = 2'd2
    } tone_t;

    localparam logic [digit_w-1:0] digit_blank = 4'hF;
    localparam logic [code_w-1:0]  disp_pass   = 12'hBCC;
    localparam logic [code_w-1:0]  disp_set    = 12'hDDD;

endpackage

//--- key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        keypad,
    output logic               key_valid,
    output lock_pkg::key_t     key_code
);

    logic [15:0]    keypad_q;    // current sample
    logic [15:0]    keypad_prev; // sample one cycle older
    lock_pkg::key_t key_dec;

    // keypad map with every other value decoded as no key
    always_comb begin
        case (keypad_q)
            16'h0001: key_dec = lock_pkg::key_enter;
            16'h0008: key_dec = lock_pkg::key_0;
            16'h0010: key_dec = lock_pkg::key_set;
            16'h0020: key_dec = lock_pkg::key_3;
            16'h0040: key_dec = lock_pkg::key_2;
            16'h0080: key_dec = lock_pkg::key_1;
            16'h0100: key_dec = lock_pkg::key_reset_tries;
            16'h0200: key_dec = lock_pkg::key_6;
            16'h0400: key_dec = lock_pkg::key_5;
            16'h0800: key_dec = lock_pkg::key_4;
            16'h1000: key_dec = lock_pkg::key_clear;
            16'h2000: key_dec = lock_pkg::key_9;
            16'h4000: key_dec = lock_pkg::key_8;
            16'h8000: key_dec = lock_pkg::key_7;
            default:  key_dec = lock_pkg::key_none;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keypad_q    <= '0;
            keypad_prev <= '0;
            key_valid   <= 1'b0;
            key_code    <= lock_pkg::key_none;
        end else begin
            keypad_q    <= keypad;
            keypad_prev <= keypad_q;
            // strobe only on the first sample of a new press
            key_valid   <= (key_dec != lock_pkg::key_none) && (keypad_q != keypad_prev);
            key_code    <= key_dec;
        end
    end

endmodule

//--- code_entry.sv
`timescale 1ns/1ps

module code_entry #(
    parameter logic [lock_pkg::code_w-1:0] init_code = 12'h246,
    parameter int                          max_tries = 3
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        key_valid,
    input  lock_pkg::key_t              key_code,
    input  logic [lock_pkg::bcd_w-1:0]  lockout_bcd,
    input  logic                        lockout_done,
    output logic [lock_pkg::code_w-1:0] display,
    output logic [1:0]                  digit_count,
    output logic [1:0]                  tries,
    output logic                        unlocked,
    output logic                        locked_out,
    output logic                        lockout_start,
    output logic                        req_pass,
    output logic                        req_fail,
    output logic                        req_click
);

    localparam logic [lock_pkg::code_w-1:0] entry_blank = {3{lock_pkg::digit_blank}};

    lock_pkg::lock_state_t          state;
    logic [lock_pkg::code_w-1:0]    entry;   // digits typed so far
    logic [lock_pkg::code_w-1:0]    code;    // stored combination
    logic [lock_pkg::digit_w-1:0]   digit;
    logic                           is_digit;
    logic                           last_try;

    assign is_digit = (key_code <= lock_pkg::key_9);
    assign digit    = key_code;
    assign last_try = (int'(tries) + 1 >= max_tries);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= lock_pkg::st_entry;
            entry         <= entry_blank;
            code          <= init_code;
            digit_count   <= 2'd0;
            tries         <= 2'd0;
            lockout_start <= 1'b0;
            req_pass      <= 1'b0;
            req_fail      <= 1'b0;
            req_click     <= 1'b0;
        end else begin
            lockout_start <= 1'b0;
            req_pass      <= 1'b0;
            req_fail      <= 1'b0;
            req_click     <= key_valid && is_digit && (state != lock_pkg::st_lockout);

            if (state == lock_pkg::st_lockout) begin
                if (lockout_done) begin // back to a blank entry
                    state       <= lock_pkg::st_entry;
                    entry       <= entry_blank;
                    digit_count <= 2'd0;
                end
            end else if (key_valid && is_digit) begin
                if (state != lock_pkg::st_unlocked && digit_count < 2'd3) begin
                    entry       <= {entry[7:0], digit}; // shift in from the right
                    digit_count <= digit_count + 2'd1;
                end
            end else if (key_valid) begin
                case (key_code)
                    lock_pkg::key_clear: begin
                        entry       <= entry_blank;
                        digit_count <= 2'd0;
                        if (state == lock_pkg::st_unlocked) begin
                            state <= lock_pkg::st_entry; // relock
                        end
                    end
                    lock_pkg::key_reset_tries: begin
                        if (state != lock_pkg::st_unlocked) begin
                            entry       <= entry_blank;
                            digit_count <= 2'd0;
                            tries       <= 2'd0;
                        end
                    end
                    lock_pkg::key_set: begin
                        if (state != lock_pkg::st_unlocked) begin
                            state       <= lock_pkg::st_set;
                            entry       <= entry_blank;
                            digit_count <= 2'd0;
                        end
                    end
                    lock_pkg::key_enter: begin
                        if (state != lock_pkg::st_unlocked && digit_count == 2'd3) begin
                            entry       <= entry_blank;
                            digit_count <= 2'd0;
                            if (state == lock_pkg::st_set) begin
                                code  <= entry; // program new code
                                tries <= 2'd0;
                                state <= lock_pkg::st_entry;
                            end else if (entry == code) begin
                                state    <= lock_pkg::st_unlocked;
                                req_pass <= 1'b1;
                            end else if (last_try) begin
                                tries         <= 2'd0;
                                lockout_start <= 1'b1;
                                req_fail      <= 1'b1;
                                state         <= lock_pkg::st_lockout;
                            end else begin
                                tries    <= tries + 2'd1;
                                req_fail <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (state)
            lock_pkg::st_unlocked: display = lock_pkg::disp_pass;
            lock_pkg::st_lockout:  display = {4'h0, lockout_bcd}; // countdown
            lock_pkg::st_set:      display = (digit_count == 2'd0) ? lock_pkg::disp_set : entry;
            default:               display = entry;
        endcase
    end

    assign unlocked   = (state == lock_pkg::st_unlocked);
    assign locked_out = (state == lock_pkg::st_lockout);

endmodule

//--- lockout_timer.sv
`timescale 1ns/1ps

module lockout_timer #(
    parameter int lockout_secs = 20,
    parameter int sec_cycles   = 50_000_000
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       lockout_start,
    output logic [lock_pkg::bcd_w-1:0] lockout_bcd,
    output logic                       lockout_done
);

    localparam int cnt_w = $clog2(sec_cycles + 1);
    localparam logic [lock_pkg::bcd_w-1:0] secs_bcd =
        {4'(lockout_secs / 10), 4'(lockout_secs % 10)};

    logic [cnt_w-1:0] pre_cnt; // cycles within one second
    logic             running;
    logic             sec_tick;

    assign sec_tick = running && (pre_cnt == cnt_w'(sec_cycles - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lockout_bcd  <= secs_bcd; // preset for the next lockout
            lockout_done <= 1'b0;
            running      <= 1'b0;
            pre_cnt      <= '0;
        end else begin
            lockout_done <= 1'b0;
            if (lockout_start) begin
                lockout_bcd <= secs_bcd;
                running     <= 1'b1;
                pre_cnt     <= '0;
            end else if (lockout_done) begin
                lockout_bcd <= secs_bcd; // reload once code_entry has seen 00
            end else if (sec_tick) begin
                pre_cnt <= '0;
                if (lockout_bcd == 8'h01) begin
                    lockout_bcd  <= 8'h00;
                    lockout_done <= 1'b1;
                    running      <= 1'b0;
                end else if (lockout_bcd[3:0] == 4'd0) begin
                    lockout_bcd <= {lockout_bcd[7:4] - 4'd1, 4'd9}; // borrow from tens
                end else begin
                    lockout_bcd[3:0] <= lockout_bcd[3:0] - 4'd1;
                end
            end else if (running) begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

//--- tone_arbiter.sv
`timescale 1ns/1ps

module tone_arbiter (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            req_click,
    input  logic            req_pass,
    input  logic            req_fail,
    input  logic            tone_busy,
    output logic            grant_valid,
    output lock_pkg::tone_t grant_tone
);

    lock_pkg::tone_t pick;     // best of this cycle's requests
    logic            any_req;
    logic            playing;

    always_comb begin
        any_req = req_click | req_pass | req_fail;
        if (req_fail) begin
            pick = lock_pkg::tone_fail;
        end else if (req_pass) begin
            pick = lock_pkg::tone_pass;
        end else begin
            pick = lock_pkg::tone_click;
        end
    end

    // generator raises busy one cycle after the grant
    assign playing = tone_busy | grant_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_valid <= 1'b0;
            grant_tone  <= lock_pkg::tone_click;
        end else begin
            grant_valid <= 1'b0;
            if (any_req && (!playing || pick > grant_tone)) begin
                grant_valid <= 1'b1;
                grant_tone  <= pick; // kept as the playing priority
            end
        end
    end

endmodule

//--- tone_generator.sv
`timescale 1ns/1ps

module tone_generator #(
    parameter int tone_unit = 25_000
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            grant_valid,
    input  lock_pkg::tone_t grant_tone,
    output logic            tone_busy,
    output logic            buzzer
);

    localparam int cyc_w = $clog2(tone_unit + 1);

    lock_pkg::tone_t tone;
    logic [cyc_w-1:0] cyc_cnt;  // cycles within a unit
    logic [5:0]       unit_cnt; // units since start
    logic [2:0]       half_cnt; // units within a half period
    logic [2:0]       half_len;
    logic [5:0]       tone_len;
    logic             sq;
    logic             mute;
    logic             unit_end;

    always_comb begin
        case (tone)
            lock_pkg::tone_click: begin
                half_len = 3'd2;
                tone_len = 6'd16;
            end
            lock_pkg::tone_pass: begin
                half_len = 3'd1;
                tone_len = 6'd48;
            end
            default: begin
                half_len = 3'd4;
                tone_len = 6'd32;
            end
        endcase
    end

    assign unit_end = (cyc_cnt == cyc_w'(tone_unit - 1));
    assign mute     = (tone == lock_pkg::tone_fail) && (unit_cnt[5:3] == 3'd1); // units 8..15
    assign buzzer   = tone_busy & sq & ~mute;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tone      <= lock_pkg::tone_click;
            tone_busy <= 1'b0;
            sq        <= 1'b0;
            cyc_cnt   <= '0;
            unit_cnt  <= '0;
            half_cnt  <= '0;
        end else if (grant_valid) begin // start or restart
            tone      <= grant_tone;
            tone_busy <= 1'b1;
            sq        <= 1'b1;
            cyc_cnt   <= '0;
            unit_cnt  <= '0;
            half_cnt  <= '0;
        end else if (tone_busy) begin
            if (unit_end) begin
                cyc_cnt <= '0;
                if (unit_cnt == tone_len - 6'd1) begin
                    tone_busy <= 1'b0;
                end else begin
                    unit_cnt <= unit_cnt + 6'd1;
                end
                if (half_cnt == half_len - 3'd1) begin
                    half_cnt <= '0;
                    sq       <= ~sq;
                end else begin
                    half_cnt <= half_cnt + 3'd1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

//--- combo_lock_top.sv
`timescale 1ns/1ps

module combo_lock_top #(
    parameter logic [lock_pkg::code_w-1:0] init_code    = 12'h246,
    parameter int                          max_tries    = 3,
    parameter int                          lockout_secs = 20,
    parameter int                          sec_cycles   = 50_000_000,
    parameter int                          tone_unit    = 25_000
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [15:0]                 keypad,
    output logic [lock_pkg::code_w-1:0] display,
    output logic [1:0]                  digit_count,
    output logic [1:0]                  tries,
    output logic                        unlocked,
    output logic                        locked_out,
    output logic                        buzzer
);

    logic                       key_valid;
    lock_pkg::key_t             key_code;
    logic                       lockout_start;
    logic [lock_pkg::bcd_w-1:0] lockout_bcd;
    logic                       lockout_done;
    logic                       req_click;
    logic                       req_pass;
    logic                       req_fail;
    logic                       grant_valid;
    lock_pkg::tone_t            grant_tone;
    logic                       tone_busy;

    key_decoder i_key_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .keypad    (keypad),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    code_entry #(
        .init_code (init_code),
        .max_tries (max_tries)
    ) i_code_entry (
        .clk           (clk),
        .arst_n        (arst_n),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .lockout_bcd   (lockout_bcd),
        .lockout_done  (lockout_done),
        .display       (display),
        .digit_count   (digit_count),
        .tries         (tries),
        .unlocked      (unlocked),
        .locked_out    (locked_out),
        .lockout_start (lockout_start),
        .req_pass      (req_pass),
        .req_fail      (req_fail),
        .req_click     (req_click)
    );

    lockout_timer #(
        .lockout_secs (lockout_secs),
        .sec_cycles   (sec_cycles)
    ) i_lockout_timer (
        .clk           (clk),
        .arst_n        (arst_n),
        .lockout_start (lockout_start),
        .lockout_bcd   (lockout_bcd),
        .lockout_done  (lockout_done)
    );

    tone_arbiter i_tone_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_click   (req_click),
        .req_pass    (req_pass),
        .req_fail    (req_fail),
        .tone_busy   (tone_busy),
        .grant_valid (grant_valid),
        .grant_tone  (grant_tone)
    );

    tone_generator #(
        .tone_unit (tone_unit)
    ) i_tone_generator (
        .clk         (clk),
        .arst_n      (arst_n),
        .grant_valid (grant_valid),
        .grant_tone  (grant_tone),
        .tone_busy   (tone_busy),
        .buzzer      (buzzer)
    );

endmodule

//--- lock_chk.sv
`timescale 1ns/1ps

module lock_chk #(
    parameter int max_tries = 3
) (
    input logic                  clk,
    input logic                  arst_n,
    input lock_pkg::lock_state_t state,
    input logic [1:0]            tries,
    input logic                  unlocked,
    input logic                  locked_out,
    input logic                  lockout_start
);

    int fail_count = 0; // read by the testbench top at the end

    tries_below_max: assert property (@(posedge clk) disable iff (!arst_n)
        state != lock_pkg::st_lockout |-> int'(tries) < max_tries)
    else begin
        fail_count++;
        $error("tries reached the failure limit outside lockout");
    end

    open_xor_locked: assert property (@(posedge clk) disable iff (!arst_n)
        !(unlocked && locked_out))
    else begin
        fail_count++;
        $error("unlocked and locked_out are high together");
    end

    start_is_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        lockout_start |=> !lockout_start)
    else begin
        fail_count++;
        $error("lockout_start held high for more than one cycle");
    end

endmodule

//--- lock_scoreboard.sv
`timescale 1ns/1ps

module lock_scoreboard #(
    parameter logic [11:0] init_code    = 12'h246,
    parameter int          max_tries    = 3,
    parameter int          lockout_secs = 20,
    parameter int          sec_cycles   = 20,
    parameter int          tone_unit    = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] keypad,
    input  logic [11:0] display,
    input  logic [1:0]  digit_count,
    input  logic [1:0]  tries,
    input  logic        unlocked,
    input  logic        locked_out,
    input  logic        buzzer,
    output int          errors
);

    string                 test_name = "reset";
    lock_pkg::lock_state_t m_state;
    logic [11:0]           m_entry;
    logic [11:0]           m_code;
    int                    m_count;
    int                    m_tries;
    int                    lock_cyc;       // cycles since the countdown showed
    logic [15:0]           kp_last;
    int                    cyc = 0;
    int                    chk_cyc = -1;   // cycle whose outputs get compared
    int                    pass_cyc;       // cycle that sampled a good enter
    logic                  pass_seen = 1'b0;

    initial errors = 0;

    function automatic lock_pkg::key_t key_of(logic [15:0] kp);
        case (kp)
            16'h0001: return lock_pkg::key_enter;
            16'h0008: return lock_pkg::key_0;
            16'h0010: return lock_pkg::key_set;
            16'h0020: return lock_pkg::key_3;
            16'h0040: return lock_pkg::key_2;
            16'h0080: return lock_pkg::key_1;
            16'h0100: return lock_pkg::key_reset_tries;
            16'h0200: return lock_pkg::key_6;
            16'h0400: return lock_pkg::key_5;
            16'h0800: return lock_pkg::key_4;
            16'h1000: return lock_pkg::key_clear;
            16'h2000: return lock_pkg::key_9;
            16'h4000: return lock_pkg::key_8;
            16'h8000: return lock_pkg::key_7;
            default:  return lock_pkg::key_none;
        endcase
    endfunction

    // reference model applied one key press at a time
    function automatic void apply_key(lock_pkg::key_t k);
        if (m_state == lock_pkg::st_lockout || k == lock_pkg::key_none) begin
            return;
        end
        if (k <= lock_pkg::key_9) begin
            if (m_state != lock_pkg::st_unlocked && m_count < 3) begin
                m_entry = {m_entry[7:0], 4'(k)};
                m_count++;
            end
        end else if (k == lock_pkg::key_clear) begin
            m_entry = 12'hFFF;
            m_count = 0;
            if (m_state == lock_pkg::st_unlocked) m_state = lock_pkg::st_entry;
        end else if (m_state == lock_pkg::st_unlocked) begin
            // other keys do nothing while open
        end else if (k == lock_pkg::key_reset_tries) begin
            m_entry = 12'hFFF;
            m_count = 0;
            m_tries = 0;
        end else if (k == lock_pkg::key_set) begin
            m_state = lock_pkg::st_set;
            m_entry = 12'hFFF;
            m_count = 0;
        end else if (k == lock_pkg::key_enter && m_count == 3) begin
            if (m_state == lock_pkg::st_set) begin
                m_code  = m_entry;
                m_tries = 0;
                m_state = lock_pkg::st_entry;
            end else if (m_entry == m_code) begin
                m_state   = lock_pkg::st_unlocked;
                pass_seen = 1'b1;
                pass_cyc  = cyc;
            end else begin
                m_tries++;
                if (m_tries >= max_tries) begin
                    m_tries  = 0;
                    m_state  = lock_pkg::st_lockout;
                    lock_cyc = -2; // countdown shows two cycles later
                end
            end
            m_entry = 12'hFFF;
            m_count = 0;
        end
    endfunction

    function automatic logic [11:0] exp_display();
        int rem;
        case (m_state)
            lock_pkg::st_unlocked: return lock_pkg::disp_pass;
            lock_pkg::st_lockout: begin
                rem = lockout_secs - ((lock_cyc >= 1) ? (lock_cyc - 1) / sec_cycles : 0);
                return {4'h0, 4'(rem / 10), 4'(rem % 10)};
            end
            lock_pkg::st_set: return (m_count == 0) ? lock_pkg::disp_set : m_entry;
            default: return m_entry;
        endcase
    endfunction

    task automatic check(input string what, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    always @(posedge clk) begin
        cyc++;
        if (!arst_n) begin
            m_state   = lock_pkg::st_entry;
            m_entry   = 12'hFFF;
            m_code    = init_code;
            m_count   = 0;
            m_tries   = 0;
            kp_last   = '0;
            pass_seen = 1'b0;
            chk_cyc   = cyc; // reset values
        end else begin
            if (m_state == lock_pkg::st_lockout) begin
                lock_cyc++;
                if (lock_cyc == 2 + lockout_secs * sec_cycles) begin // done seen
                    m_state = lock_pkg::st_entry;
                    m_entry = 12'hFFF;
                    m_count = 0;
                end
            end
            if (keypad !== kp_last) begin
                kp_last = keypad;
                chk_cyc = cyc + 2;
                apply_key(key_of(keypad));
            end
        end
    end

    always @(negedge clk) begin
        if (cyc == chk_cyc) begin
            check("display", exp_display(), display);
            check("digit_count", m_count, digit_count);
            check("tries", m_tries, tries);
            check("unlocked", m_state == lock_pkg::st_unlocked, unlocked);
            check("locked_out", m_state == lock_pkg::st_lockout, locked_out);
        end
        // pass tone starts four cycles after the enter sample
        if (pass_seen && cyc - pass_cyc >= 4 && cyc - pass_cyc < 4 + 4 * tone_unit) begin
            check("buzzer", ((cyc - pass_cyc - 4) / tone_unit) % 2 == 0, buzzer);
        end
    end

endmodule

//--- lock_tb.sv
`timescale 1ns/1ps

module lock_tb;

    localparam logic [11:0] init_code    = 12'h246;
    localparam int          max_tries    = 3;
    localparam int          lockout_secs = 20;
    localparam int          sec_cycles   = 20;
    localparam int          tone_unit    = 2;
    localparam int          press_budget = 60; // key presses outside the lockout wait
    localparam int          wd_cycles    = press_budget * 6
                                           + 2 * (lockout_secs * sec_cycles + 10) + 400;

    // keypad lines of digits 0 to 9
    localparam logic [15:0] digit_lines [10] = '{16'h0008, 16'h0080, 16'h0040, 16'h0020,
        16'h0800, 16'h0400, 16'h0200, 16'h8000, 16'h4000, 16'h2000};
    localparam logic [15:0] enter_line = 16'h0001;
    localparam logic [15:0] set_line   = 16'h0010;
    localparam logic [15:0] clear_line = 16'h1000;
    localparam logic [15:0] rst_line   = 16'h0100;

    logic        clk;
    logic        arst_n;
    logic [15:0] keypad;
    logic [11:0] display;
    logic [1:0]  digit_count;
    logic [1:0]  tries;
    logic        unlocked;
    logic        locked_out;
    logic        buzzer;
    int          sb_errors;
    int          chk_errors;
    int          d0;
    int          d1;
    int          d2;

    combo_lock_top #(
        .init_code    (init_code),
        .max_tries    (max_tries),
        .lockout_secs (lockout_secs),
        .sec_cycles   (sec_cycles),
        .tone_unit    (tone_unit)
    ) i_combo_lock_top (.*);

    lock_scoreboard #(
        .init_code    (init_code),
        .max_tries    (max_tries),
        .lockout_secs (lockout_secs),
        .sec_cycles   (sec_cycles),
        .tone_unit    (tone_unit)
    ) i_scoreboard (.*, .errors(sb_errors));

    bind code_entry lock_chk #(.max_tries(max_tries)) i_lock_chk (.*);

    // one press held 3 cycles then released 3 cycles
    task automatic press(input logic [15:0] line);
        @(negedge clk);
        keypad = line;
        repeat (3) @(negedge clk);
        keypad = '0;
        repeat (2) @(negedge clk);
    endtask

    task automatic enter_code(input int a, input int b, input int c);
        press(digit_lines[a]);
        press(digit_lines[b]);
        press(digit_lines[c]);
        press(enter_line);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired, the tests did not finish within %0d cycles", wd_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h3644));
        keypad = '0;
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        i_scoreboard.test_name = "digit_entry";
        repeat (4) press(digit_lines[$urandom % 10]); // fourth one is ignored
        press(clear_line);

        i_scoreboard.test_name = "correct_code";
        enter_code(2, 4, 6);
        press(clear_line);

        i_scoreboard.test_name = "wrong_code";
        repeat (max_tries) enter_code(1, 3, 5);
        repeat (3) press(digit_lines[$urandom % 10]);
        while (locked_out) press(16'h0003); // two lines give no key
        press(clear_line);

        i_scoreboard.test_name = "program_code";
        d0 = $urandom % 9; // keeps 999 out of the new code
        d1 = $urandom % 10;
        d2 = $urandom % 10;
        if (d0 == 2 && d1 == 4 && d2 == 6) begin
            d2 = 7; // new code differs from the old one
        end
        press(set_line);
        enter_code(d0, d1, d2);
        enter_code(d0, d1, d2);
        press(clear_line);
        enter_code(2, 4, 6); // old code
        press(rst_line);

        i_scoreboard.test_name = "illegal_keys";
        press(16'h0041);
        press(16'hFFFF);
        press(digit_lines[1]);
        press(digit_lines[2]);
        press(enter_line); // short entry
        press(clear_line);
        enter_code(9, 9, 9);
        press(rst_line);

        repeat (4) @(negedge clk);
        chk_errors = i_combo_lock_top.i_code_entry.i_lock_chk.fail_count;
        $display("errors: %0d scoreboard, %0d assertion", sb_errors, chk_errors);
        if (sb_errors + chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
lock_pkg.sv
key_decoder.sv
code_entry.sv
lockout_timer.sv
tone_arbiter.sv
tone_generator.sv
combo_lock_top.sv
lock_chk.sv
lock_scoreboard.sv
lock_tb.sv
